//--- sim.f
rv_div_pkg.sv
div_operand_prep.sv
div_nonrestore_core.sv
div_result_fix.sv
mdu_div_top.sv
mdu_div_sva.sv
tb_mdu_div.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_mdu_div -f sim.f

result=$(./obj_dir/Vtb_mdu_div) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -q "^Everything OK$"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb_mdu_div.sv
`timescale 1ns/100ps

module tb_mdu_div import rv_div_pkg::*; ();

    localparam int XLEN = 64;
    localparam int NUM_RANDOM = 200;
    localparam logic [63:0] MIN64 = 64'h8000_0000_0000_0000;

    logic            clk;
    logic            rst;
    logic            req_valid;
    logic            req_ready;
    div_op_e         req_op;
    logic [XLEN-1:0] req_rs1;
    logic [XLEN-1:0] req_rs2;
    logic            resp_valid;
    logic            resp_ready;
    logic [XLEN-1:0] resp_result;

    integer seed = 15;

    // stimulus built at time zero
    div_op_e     vec_op[$];
    logic [63:0] vec_a[$];
    logic [63:0] vec_b[$];
    int          vec_gap[$];

    // expected results in request order
    logic [63:0] exp_q[$];

    int req_count;
    int resp_count;
    int cycles;
    int max_cycles;

    mdu_div_top #(.XLEN(XLEN)) DUT (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
        .req_rs1(req_rs1), .req_rs2(req_rs2),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_result(resp_result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // isa reference model
    // division by zero and overflow handled first
    function automatic logic [63:0] model_result(div_op_e op, logic [63:0] a, logic [63:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] sa32;
        logic signed [31:0] sb32;
        logic [31:0]        r32;
        logic [63:0]        r;
        sa   = a;
        sb   = b;
        sa32 = a[31:0];
        sb32 = b[31:0];
        r32  = '0;
        r    = '0;
        case (op)
            op_div, op_rem: begin
                if (b == '0) begin
                    r = (op == op_div) ? '1 : a;
                end else if ((a == MIN64) && (b == '1)) begin
                    r = (op == op_div) ? a : '0;
                end else if (op == op_div) begin
                    r = sa / sb;
                end else begin
                    r = sa % sb;
                end
            end
            op_divu, op_remu: begin
                if (b == '0) begin
                    r = (op == op_divu) ? '1 : a;
                end else if (op == op_divu) begin
                    r = a / b;
                end else begin
                    r = a % b;
                end
            end
            op_divw, op_remw: begin
                if (b[31:0] == '0) begin
                    r32 = (op == op_divw) ? '1 : a[31:0];
                end else if ((a[31:0] == 32'h8000_0000) && (b[31:0] == '1)) begin
                    r32 = (op == op_divw) ? a[31:0] : '0;
                end else if (op == op_divw) begin
                    r32 = sa32 / sb32;
                end else begin
                    r32 = sa32 % sb32;
                end
                r = {{32{r32[31]}}, r32};
            end
            default: begin
                // divuw and remuw
                if (b[31:0] == '0) begin
                    r32 = (op == op_divuw) ? '1 : a[31:0];
                end else if (op == op_divuw) begin
                    r32 = a[31:0] / b[31:0];
                end else begin
                    r32 = a[31:0] % b[31:0];
                end
                r = {{32{r32[31]}}, r32};
            end
        endcase
        return r;
    endfunction

    task automatic add_vec(input div_op_e op, input logic [63:0] a, input logic [63:0] b);
        vec_op.push_back(op);
        vec_a.push_back(a);
        vec_b.push_back(b);
        // occasional idle cycle before the request
        vec_gap.push_back((($random(seed) & 3) == 0) ? 1 : 0);
    endtask

    // operand of small magnitude or 32-bit range or full width
    task automatic random_operand(output logic [63:0] v);
        logic [31:0] hi;
        logic [31:0] lo;
        int          sel;
        hi  = $random(seed);
        lo  = $random(seed);
        sel = $random(seed) & 3;
        case (sel)
            0: v = 64'(lo[7:0]);
            1: v = -64'(lo[7:0]);
            2: v = {{32{hi[31]}}, lo};
            default: v = {hi, lo};
        endcase
    endtask

    task automatic build_vectors();
        logic [63:0] ca[16];
        logic [63:0] cb[16];
        logic [63:0] a;
        logic [63:0] b;
        int          k;
        int          i;
        int          o;
        // zero divisors, overflow, mixed signs, exact negatives
        ca = '{64'hdead_beef_8765_4321, 64'h1234_5678_ffff_fff9, MIN64,
               64'h1234_5678_8000_0000, -64'd7, 64'd7, -64'd7, 64'd7,
               -64'd6, -64'd6, 64'd6, 64'd0, MIN64, 64'h7fff_ffff_ffff_ffff,
               64'hffff_ffff_7fff_fff9, -64'd1};
        cb = '{64'd0, 64'hffff_ffff_0000_0000, -64'd1,
               64'h0000_0000_ffff_ffff, 64'd2, -64'd2, -64'd2, 64'd2,
               64'd3, -64'd3, -64'd3, 64'd5, 64'd1, MIN64,
               64'haaaa_aaaa_ffff_fffe, -64'd1};
        for (i = 0; i < 16; i++) begin
            for (o = 0; o < 8; o++) begin
                add_vec(div_op_e'(o), ca[i], cb[i]);
            end
        end
        for (i = 0; i < NUM_RANDOM; i++) begin
            k = $random(seed) & 7;
            random_operand(a);
            random_operand(b);
            add_vec(div_op_e'(k), a, b);
        end
    endtask

    // called on a falling edge
    // returns one falling edge after the accept
    task automatic send_request(input div_op_e op, input logic [63:0] a, input logic [63:0] b);
        req_valid = 1'b1;
        req_op    = op;
        req_rs1   = a;
        req_rs2   = b;
        // req_ready comes from registers only
        while (!req_ready) begin
            @(negedge clk);
        end
        exp_q.push_back(model_result(op, a, b));
        req_count++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    initial begin : stimulus
        int i;
        req_valid  = 1'b0;
        req_op     = op_div;
        req_rs1    = '0;
        req_rs2    = '0;
        resp_ready = 1'b0;
        rst        = 1'b1;
        req_count  = 0;
        resp_count = 0;
        build_vectors();
        max_cycles = vec_op.size() * (XLEN + 10) + 200;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (i = 0; i < vec_op.size(); i++) begin
            repeat (vec_gap[i]) @(negedge clk);
            send_request(vec_op[i], vec_a[i], vec_b[i]);
        end
        wait (resp_count == req_count);
        // nothing extra may follow the last response
        repeat (5) @(negedge clk);
        if ((resp_count == req_count) && (exp_q.size() == 0) && !resp_valid) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("extra response after the last request: %0d responses for %0d requests",
                     resp_count, req_count);
            $display("Something failed");
            $fatal(1, "response count");
        end
    end

    // random stalls on resp_ready
    // results checked while the handshake is pending
    initial begin : response_side
        logic [63:0] expected;
        forever begin
            @(negedge clk);
            resp_ready = ($random(seed) & 3) != 0;
            if (!rst && resp_valid && resp_ready) begin
                assert (exp_q.size() > 0) else begin
                    $display("response at %0t arrived with no request outstanding", $time);
                    $display("Something failed");
                    $fatal(1, "extra response");
                end
                expected = exp_q.pop_front();
                assert (resp_result === expected) else begin
                    $display("mismatch at %0t: response %0d got %h expected %h", $time,
                             resp_count, resp_result, expected);
                    $display("Something failed");
                    $fatal(1, "result mismatch");
                end
                resp_count++;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        @(posedge clk);
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d responses received", cycles,
                 resp_count, req_count);
        $display("Something failed");
        $fatal(1, "timeout");
    end

endmodule

//--- mdu_div_sva.sv
`timescale 1ns/100ps

module mdu_div_sva #(
    parameter int XLEN = 64
) (
    input logic            clk,
    input logic            rst,
    input logic            req_ready,
    input logic            resp_valid,
    input logic            resp_ready,
    input logic [XLEN-1:0] resp_result
);

    // pending response neither drops nor changes
    resp_hold: assert property (
        @(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_result)
    ) else $error("response dropped or changed before it was accepted");

    // unit stays closed while a response waits
    ready_blocked: assert property (
        @(posedge clk) disable iff (rst)
        resp_valid |-> !req_ready
    ) else $error("req_ready high while a response is pending");

    // idle and open right after a reset cycle
    reset_state: assert property (
        @(posedge clk)
        rst |=> !resp_valid && req_ready
    ) else $error("unit not idle after reset");

endmodule

bind mdu_div_top mdu_div_sva #(.XLEN(XLEN)) u_sva (
    .clk(clk),
    .rst(rst),
    .req_ready(req_ready),
    .resp_valid(resp_valid),
    .resp_ready(resp_ready),
    .resp_result(resp_result)
);

//--- mdu_div_top.sv
`timescale 1ns/100ps

module mdu_div_top import rv_div_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    output logic            req_ready,
    input  div_op_e         req_op,
    input  logic [XLEN-1:0] req_rs1,
    input  logic [XLEN-1:0] req_rs2,
    output logic            resp_valid,
    input  logic            resp_ready,
    output logic [XLEN-1:0] resp_result
);

    // rv32 or rv64 only
    if ((XLEN != 32) && (XLEN != DIV_XLEN_MAX)) begin : g_bad_xlen
        $error("mdu_div_top: XLEN must be 32 or %0d", DIV_XLEN_MAX);
    end

    // prep to core
    logic            start;
    logic [XLEN:0]   op_a;
    logic [XLEN:0]   op_b;
    logic            special;
    div_op_e         core_op;
    logic [XLEN-1:0] special_result;

    // core to fix
    logic            done;
    logic [XLEN:0]   raw_rem;
    logic [XLEN:0]   raw_quot;
    logic            a_neg;
    logic            b_neg;
    logic [XLEN:0]   divisor;
    logic            bypass;
    div_op_e         fix_op;

    // fix back to prep
    logic            resp_busy;

    div_operand_prep #(.XLEN(XLEN)) u_prep (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_op(req_op),
        .req_rs1(req_rs1), .req_rs2(req_rs2),
        .resp_busy(resp_busy), .req_ready(req_ready),
        .start(start), .op_a(op_a), .op_b(op_b),
        .special(special), .special_result(special_result), .core_op(core_op)
    );

    div_nonrestore_core #(.XLEN(XLEN)) u_core (
        .clk(clk), .rst(rst),
        .start(start), .op_a(op_a), .op_b(op_b),
        .special(special), .core_op(core_op),
        .done(done), .raw_rem(raw_rem), .raw_quot(raw_quot),
        .a_neg(a_neg), .b_neg(b_neg), .divisor(divisor),
        .bypass(bypass), .fix_op(fix_op)
    );

    div_result_fix #(.XLEN(XLEN)) u_fix (
        .clk(clk), .rst(rst),
        .done(done), .raw_rem(raw_rem), .raw_quot(raw_quot),
        .a_neg(a_neg), .b_neg(b_neg), .divisor(divisor),
        .bypass(bypass), .fix_op(fix_op), .special_result(special_result),
        .resp_ready(resp_ready), .resp_valid(resp_valid),
        .resp_result(resp_result), .resp_busy(resp_busy)
    );

endmodule

//--- div_result_fix.sv
`timescale 1ns/100ps

module div_result_fix import rv_div_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            done,
    input  logic [XLEN:0]   raw_rem,
    input  logic [XLEN:0]   raw_quot,
    input  logic            a_neg,
    input  logic            b_neg,
    input  logic [XLEN:0]   divisor,
    input  logic            bypass,
    input  div_op_e         fix_op,
    input  logic [XLEN-1:0] special_result,
    input  logic            resp_ready,
    output logic            resp_valid,
    output logic [XLEN-1:0] resp_result,
    output logic            resp_busy
);

    localparam int W = XLEN + 1;

    logic            signs_differ;
    logic [W-1:0]    neg_abs_d;
    logic            exact_neg;
    logic            rem_wrong_sign;
    logic [W-1:0]    quot_fix;
    logic [W-1:0]    rem_fix;
    logic [XLEN-1:0] pick;
    logic [XLEN-1:0] result_d;

    always_comb begin
        signs_differ   = a_neg ^ b_neg;
        // minus |divisor|
        neg_abs_d      = b_neg ? divisor : -divisor;
        // negative dividend divides exactly when the raw remainder
        // lands on zero or on -|divisor|
        exact_neg      = a_neg & ((raw_rem == '0) | (raw_rem == neg_abs_d));
        rem_wrong_sign = raw_rem[W-1] ^ a_neg;

        if (exact_neg) begin
            quot_fix = raw_quot + W'(b_neg);
            rem_fix  = '0;
        end else begin
            // recorded digits are off by one for unlike signs
            quot_fix = raw_quot + W'(signs_differ);
            // pull remainder back to the sign of the dividend
            if (!rem_wrong_sign) begin
                rem_fix = raw_rem;
            end else if (signs_differ) begin
                rem_fix = raw_rem - divisor;
            end else begin
                rem_fix = raw_rem + divisor;
            end
        end

        if (is_rem_op(fix_op)) begin
            pick = rem_fix[XLEN-1:0];
        end else begin
            pick = quot_fix[XLEN-1:0];
        end

        // word results sign-extended from bit 31
        if (bypass) begin
            result_d = special_result;
        end else if (is_word_op(fix_op)) begin
            result_d = XLEN'($signed(pick[31:0]));
        end else begin
            result_d = pick;
        end
    end

    // held until the consumer takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (done) begin
            resp_valid <= 1'b1;
        end else if (resp_valid && resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            resp_result <= result_d;
        end
    end

    // blocks new requests in prep
    assign resp_busy = resp_valid;

endmodule

//--- div_nonrestore_core.sv
`timescale 1ns/100ps

module div_nonrestore_core import rv_div_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic          clk,
    input  logic          rst,
    // operands valid during the start pulse
    input  logic          start,
    input  logic [XLEN:0] op_a,
    input  logic [XLEN:0] op_b,
    input  logic          special,
    input  div_op_e       core_op,
    // one-cycle pulse, results below valid with it
    output logic          done,
    output logic [XLEN:0] raw_rem,
    output logic [XLEN:0] raw_quot,
    output logic          a_neg,
    output logic          b_neg,
    output logic [XLEN:0] divisor,
    output logic          bypass,
    output div_op_e       fix_op
);

    // extended operand width
    localparam int W = XLEN + 1;

    // counter value of the final step
    localparam logic [DIV_CNT_W-1:0] LAST_STEP = DIV_CNT_W'(XLEN);

    logic                 busy;
    logic [DIV_CNT_W-1:0] cnt;

    // one iteration of the datapath
    logic [W-1:0] shifted;
    logic         subtract;
    logic [W-1:0] step_sum;
    logic         q_bit;

    /*
     * {raw_rem, raw_quot} is one 2W-bit shift register
     *
     *   start: raw_rem  = all copies of the dividend sign
     *          raw_quot = dividend
     *   step:  shift left one bit, quotient msb moves into the remainder
     *          add or subtract the divisor
     *          new quotient bit enters at the lsb
     *
     * after W steps raw_rem holds the uncorrected remainder
     * and raw_quot the recorded digits, fixed up downstream
     */

    always_comb begin
        shifted = {raw_rem[W-2:0], raw_quot[W-1]};
        // sign taken before the shift, the shifted value may wrap
        subtract = (raw_rem[W-1] == b_neg);
        if (subtract) begin
            step_sum = shifted - divisor;
        end else begin
            step_sum = shifted + divisor;
        end
        // digit for the next step
        q_bit = ~(step_sum[W-1] ^ b_neg);
    end

    // iteration control
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                // special cases skip straight to done
                busy <= ~special;
                cnt  <= '0;
                done <= special;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST_STEP) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // operand capture and shift register
    always_ff @(posedge clk) begin
        if (start) begin
            raw_rem  <= {W{op_a[W-1]}};
            raw_quot <= op_a;
            divisor  <= op_b;
            a_neg    <= op_a[W-1];
            b_neg    <= op_b[W-1];
            bypass   <= special;
            fix_op   <= core_op;
        end else if (busy) begin
            raw_rem  <= step_sum;
            raw_quot <= {raw_quot[W-2:0], q_bit};
        end
    end

endmodule

//--- div_operand_prep.sv
`timescale 1ns/100ps

module div_operand_prep import rv_div_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_valid,
    input  div_op_e         req_op,
    input  logic [XLEN-1:0] req_rs1,
    input  logic [XLEN-1:0] req_rs2,
    input  logic            resp_busy,
    output logic            req_ready,
    output logic            start,
    output logic [XLEN:0]   op_a,
    output logic [XLEN:0]   op_b,
    output logic            special,
    output logic [XLEN-1:0] special_result,
    output div_op_e         core_op
);

    localparam int W = XLEN + 1;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic            busy;
    logic            accept;
    div_op_e         op_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic            sgn;
    logic            word;
    logic            illegal;
    logic            div_zero;
    logic            overflow;
    logic [31:0]     a32;
    logic [31:0]     b32;
    logic [XLEN-1:0] dividend_res;

    // one request in flight, none while a response waits
    assign req_ready = ~busy & ~resp_busy;
    assign accept    = req_valid & req_ready;
    assign core_op   = op_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= accept;
            // handed over once the response register fills
            if (accept) begin
                busy <= 1'b1;
            end else if (resp_busy) begin
                busy <= 1'b0;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= req_op;
            rs1_q <= req_rs1;
            rs2_q <= req_rs2;
        end
    end

    always_comb begin
        sgn  = is_signed_op(op_q);
        word = is_word_op(op_q);
        // no word forms on rv32
        illegal = (XLEN == 32) && word;
        a32  = rs1_q[31:0];
        b32  = rs2_q[31:0];
        if (word) begin
            // low half only, upper input bits ignored
            op_a         = sgn ? W'($signed(a32)) : W'(a32);
            op_b         = sgn ? W'($signed(b32)) : W'(b32);
            div_zero     = (b32 == '0);
            overflow     = sgn && (a32 == 32'h8000_0000) && (b32 == '1);
            dividend_res = XLEN'($signed(a32));
        end else begin
            // one extra sign or zero bit on top
            op_a         = {sgn & rs1_q[XLEN-1], rs1_q};
            op_b         = {sgn & rs2_q[XLEN-1], rs2_q};
            div_zero     = (rs2_q == '0);
            overflow     = sgn && (rs1_q == MOST_NEG) && (rs2_q == '1);
            dividend_res = rs1_q;
        end
        special = div_zero | overflow | illegal;
        // isa answers, illegal ops return zero
        if (illegal) begin
            special_result = '0;
        end else if (div_zero) begin
            special_result = is_rem_op(op_q) ? dividend_res : '1;
        end else begin
            special_result = is_rem_op(op_q) ? '0 : dividend_res;
        end
    end

endmodule

//--- rv_div_pkg.sv
package rv_div_pkg;

    // widest datapath the divider supports
    localparam int DIV_XLEN_MAX = 64;

    // iteration counter width, counts 0 to DIV_XLEN_MAX
    localparam int DIV_CNT_W = $clog2(DIV_XLEN_MAX + 1);

    // M-extension divide opcodes
    // upper four are the 32-bit word forms
    typedef enum logic [2:0] {
        op_div   = 3'd0,
        op_divu  = 3'd1,
        op_rem   = 3'd2,
        op_remu  = 3'd3,
        op_divw  = 3'd4,
        op_divuw = 3'd5,
        op_remw  = 3'd6,
        op_remuw = 3'd7
    } div_op_e;

    // operands treated as two's complement
    function automatic logic is_signed_op(div_op_e op);
        return op inside {op_div, op_rem, op_divw, op_remw};
    endfunction

    // operates on bits 31:0, result sign-extended
    function automatic logic is_word_op(div_op_e op);
        return op inside {op_divw, op_divuw, op_remw, op_remuw};
    endfunction

    // remainder wanted instead of quotient
    function automatic logic is_rem_op(div_op_e op);
        return op inside {op_rem, op_remu, op_remw, op_remuw};
    endfunction

endpackage
